/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_spike_sort \
		-f project.f -o sim_tb

run: compile
	-./obj_dir/sim_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* mua_if.sv */
`timescale 1ns/1ps

interface mua_if;

  logic                valid;
  spike_pkg::ch_t      ch;
  spike_pkg::sample_t  sample;
  spike_pkg::sample_t  thr;

  // Lookup stage drives the sample with its threshold
  modport src (output valid, output ch, output sample, output thr);

  // Detector consumes everything
  modport snk (input valid, input ch, input sample, input thr);

  // Control only watches for the frame boundary
  modport mon (input valid, input ch);

endinterface

/* project.f */
+incdir+.
spike_pkg.sv
mua_if.sv
spike_ctrl.sv
thr_ram.sv
spike_detect.sv
spike_info_fifo.sv
spike_sort_top.sv
tb_spike_sort.sv

/* spike_config.svh */
`ifndef SPIKE_CONFIG_SVH
`define SPIKE_CONFIG_SVH

// Channels per frame, in arrival order 0..N-1
`define SPK_NUM_CH 32

// Width of a channel index
`define SPK_CH_W 5

// Band-passed sample and threshold width, signed
`define SPK_SAMPLE_W 16

// Frame counter width, also the upper half of a spike record
`define SPK_FRAME_W 32

// Spike records held before overflow
`define SPK_FIFO_DEPTH 16

`endif

/* spike_ctrl.sv */
`timescale 1ns/1ps
`include "spike_config.svh"

module spike_ctrl (
  input  logic                bus_clk,
  input  logic                reset,
  input  logic                running,
  mua_if.mon                  mua,
  output spike_pkg::frame_t   frame_no,
  output logic                clear
);

  localparam spike_pkg::ch_t LAST_CH = spike_pkg::ch_t'(`SPK_NUM_CH - 1);

  spike_pkg::run_state_t state;
  logic                  frame_end;

  // Last channel of a frame seen on the lookup output
  assign frame_end = mua.valid && (mua.ch == LAST_CH);

  // Detector stays re-armed whenever acquisition is stopped
  assign clear = (state == spike_pkg::ST_IDLE);

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      state    <= spike_pkg::ST_IDLE;
      frame_no <= '0;
    end else begin
      case (state)
        spike_pkg::ST_IDLE: begin
          frame_no <= '0;
          if (running) begin
            state <= spike_pkg::ST_RUN;
          end
        end
        spike_pkg::ST_RUN: begin
          if (!running) begin
            state    <= spike_pkg::ST_IDLE;
            frame_no <= '0;
          end else if (frame_end) begin
            frame_no <= frame_no + 1'b1;
          end
        end
        default: begin
          state <= spike_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Frame count frozen over consecutive idle cycles
  property p_idle_frame_stable;
    @(posedge bus_clk) disable iff (reset)
      (state == spike_pkg::ST_IDLE) ##1 (state == spike_pkg::ST_IDLE) |-> $stable(frame_no);
  endproperty

  a_idle_frame_stable: assert property (p_idle_frame_stable)
    else $error("frame_no moved while idle");

endmodule

/* spike_detect.sv */
`timescale 1ns/1ps
`include "spike_config.svh"

module spike_detect (
  input  logic                bus_clk,
  input  logic                reset,
  mua_if.snk                  mua,
  input  spike_pkg::frame_t   frame_no,
  input  logic                clear,
  output logic                evt_valid,
  output spike_pkg::spk_rec_t evt_rec
);

  // Set means the channel may fire on its next downward crossing
  logic [`SPK_NUM_CH-1:0] armed;
  logic                   below;
  logic                   fire;

  // Signed compare, both sides are sample_t
  assign below = (mua.sample < mua.thr);
  assign fire  = mua.valid && !clear && below && armed[mua.ch];

  always_ff @(posedge bus_clk) begin
    if (reset || clear) begin
      armed     <= '1;
      evt_valid <= 1'b0;
    end else begin
      evt_valid <= fire;
      if (mua.valid) begin
        if (fire) begin
          armed[mua.ch] <= 1'b0;
        end else if (!below) begin
          armed[mua.ch] <= 1'b1;
        end
      end
    end
  end

  // Record payload
  always_ff @(posedge bus_clk) begin
    if (fire) begin
      evt_rec <= {frame_no, spike_pkg::host_word_t'(mua.ch)};
    end
  end

  // A clear must suppress any event in the following cycle
  property p_no_evt_after_clear;
    @(posedge bus_clk) disable iff (reset)
      clear |=> !evt_valid;
  endproperty

  a_no_evt_after_clear: assert property (p_no_evt_after_clear)
    else $error("spike event right after clear");

endmodule

/* spike_info_fifo.sv */
`timescale 1ns/1ps
`include "spike_config.svh"

module spike_info_fifo (
  input  logic                  bus_clk,
  input  logic                  reset,
  input  logic                  spk_open,
  input  logic                  evt_valid,
  input  spike_pkg::spk_rec_t   evt_rec,
  input  logic                  spk_rden,
  output spike_pkg::host_word_t spk_rdata,
  output logic                  spk_empty,
  output logic                  overflow
);

  localparam int AW = $clog2(`SPK_FIFO_DEPTH);
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(`SPK_FIFO_DEPTH);

  spike_pkg::spk_rec_t rec_mem [`SPK_FIFO_DEPTH];

  // Extra MSB separates full from empty
  logic [AW:0]         wr_ptr;
  logic [AW:0]         rd_ptr;
  logic [AW:0]         fill;
  logic                full;
  logic                wr_en;
  logic                pop;
  // Low half of the head record is on the bus when set
  logic                half_sel;
  spike_pkg::spk_rec_t head;

  assign fill      = wr_ptr - rd_ptr;
  assign full      = (fill == FULL_CNT);
  assign spk_empty = (wr_ptr == rd_ptr);
  assign wr_en     = evt_valid && !full;
  assign pop       = spk_rden && !spk_empty;

  // First word falls through, upper half first
  assign head      = rec_mem[rd_ptr[AW-1:0]];
  assign spk_rdata = half_sel ? head[31:0] : head[63:32];

  always_ff @(posedge bus_clk) begin
    if (wr_en) begin
      rec_mem[wr_ptr[AW-1:0]] <= evt_rec;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (reset || !spk_open) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      half_sel <= 1'b0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Sticky until the host closes the stream
      if (evt_valid && full) begin
        overflow <= 1'b1;
      end
      if (pop) begin
        half_sel <= !half_sel;
        if (half_sel) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Occupancy bounded by the depth
  a_fill_bound: assert property (
    @(posedge bus_clk) disable iff (reset)
      fill <= FULL_CNT
  ) else $error("write pointer ran past read pointer");

  // Read pointer only advances out of a non-empty queue
  a_no_pop_empty: assert property (
    @(posedge bus_clk) disable iff (reset)
      (spk_open && $past(spk_open) && (rd_ptr != $past(rd_ptr))) |-> $past(!spk_empty)
  ) else $error("record popped while empty");

endmodule

/* spike_pkg.sv */
`include "spike_config.svh"

package spike_pkg;

  // Channel index within a frame
  typedef logic [`SPK_CH_W-1:0] ch_t;

  // Filtered sample or per-channel threshold
  typedef logic signed [`SPK_SAMPLE_W-1:0] sample_t;

  // Frame number since acquisition started
  typedef logic [`SPK_FRAME_W-1:0] frame_t;

  // One word as the host reads it
  typedef logic [31:0] host_word_t;

  // Spike record, frame number on top, channel below
  typedef logic [63:0] spk_rec_t;

  // Acquisition run state
  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } run_state_t;

endpackage

/* spike_sort_top.sv */
`timescale 1ns/1ps

module spike_sort_top (
  input  logic                  bus_clk,
  input  logic                  reset,

  input  logic                  thr_wren,
  input  logic                  thr_rden,
  input  spike_pkg::ch_t        thr_addr,
  input  spike_pkg::sample_t    thr_wdata,
  output spike_pkg::sample_t    thr_rdata,

  input  logic                  sample_valid,
  input  spike_pkg::ch_t        sample_ch,
  input  spike_pkg::sample_t    sample_data,

  input  logic                  running,

  input  logic                  spk_open,
  input  logic                  spk_rden,
  output logic                  spk_empty,
  output spike_pkg::host_word_t spk_rdata,

  output logic                  overflow
);

  mua_if mua ();

  spike_pkg::frame_t   frame_no;
  logic                clear;
  logic                evt_valid;
  spike_pkg::spk_rec_t evt_rec;

  spike_ctrl u_spike_ctrl (
    .bus_clk  (bus_clk  ),
    .reset    (reset    ),
    .running  (running  ),
    .mua      (mua.mon  ),
    .frame_no (frame_no ),
    .clear    (clear    )
  );

  // Threshold table and sample lookup
  thr_ram u_thr_ram (
    .bus_clk      (bus_clk      ),
    .thr_wren     (thr_wren     ),
    .thr_rden     (thr_rden     ),
    .thr_addr     (thr_addr     ),
    .thr_wdata    (thr_wdata    ),
    .thr_rdata    (thr_rdata    ),
    .sample_valid (sample_valid ),
    .sample_ch    (sample_ch    ),
    .sample_data  (sample_data  ),
    .mua          (mua.src      )
  );

  spike_detect u_spike_detect (
    .bus_clk   (bus_clk   ),
    .reset     (reset     ),
    .mua       (mua.snk   ),
    .frame_no  (frame_no  ),
    .clear     (clear     ),
    .evt_valid (evt_valid ),
    .evt_rec   (evt_rec   )
  );

  // Host-facing record queue
  spike_info_fifo u_spike_info_fifo (
    .bus_clk   (bus_clk   ),
    .reset     (reset     ),
    .spk_open  (spk_open  ),
    .evt_valid (evt_valid ),
    .evt_rec   (evt_rec   ),
    .spk_rden  (spk_rden  ),
    .spk_rdata (spk_rdata ),
    .spk_empty (spk_empty ),
    .overflow  (overflow  )
  );

endmodule

/* tb_spike_sort.sv */
`timescale 1ns/1ps
`include "spike_config.svh"

module tb_spike_sort;

  localparam int TIMEOUT  = 200;
  localparam int NUM_ROWS = 28;

  typedef enum logic [2:0] {OP_THR, OP_FRAME, OP_RUN, OP_OPEN, OP_DRAIN} op_t;
  typedef enum logic [1:0] {K_ONE, K_ALL, K_RAND} kind_t;

  // Frames for OP_FRAME or records for OP_DRAIN
  // All ones accepts any record count
  typedef struct packed {
    op_t                op;
    kind_t              kind;
    spike_pkg::ch_t     ch;
    spike_pkg::sample_t val;
    logic [15:0]        n;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{OP_RUN,   K_ONE,  5'd0,  16'sd1,      16'd0},
    '{OP_THR,   K_ONE,  5'd5,  16'sd100,    16'd0},
    '{OP_THR,   K_ONE,  5'd9,  -16'sd200,   16'd0},
    '{OP_THR,   K_ONE,  5'd20, 16'sd0,      16'd0},
    '{OP_FRAME, K_ONE,  5'd5,  16'sd500,    16'd2},
    '{OP_FRAME, K_ONE,  5'd5,  16'sd50,     16'd1},
    '{OP_FRAME, K_ONE,  5'd5,  -16'sd300,   16'd3},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'd1},
    '{OP_FRAME, K_ONE,  5'd5,  16'sd100,    16'd1},
    '{OP_FRAME, K_ONE,  5'd5,  16'sd99,     16'd1},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'd1},
    '{OP_FRAME, K_RAND, 5'd0,  16'sd0,      16'd2},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'hffff},
    '{OP_FRAME, K_RAND, 5'd0,  16'sd0,      16'd2},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'hffff},
    '{OP_FRAME, K_RAND, 5'd0,  16'sd0,      16'd2},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'hffff},
    '{OP_FRAME, K_ONE,  5'd9,  -16'sd500,   16'd1},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'hffff},
    '{OP_RUN,   K_ONE,  5'd0,  16'sd0,      16'd0},
    '{OP_RUN,   K_ONE,  5'd0,  16'sd1,      16'd0},
    '{OP_FRAME, K_ONE,  5'd9,  -16'sd500,   16'd1},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'd1},
    '{OP_FRAME, K_ALL,  5'd0,  16'sh7fff,   16'd1},
    '{OP_FRAME, K_ALL,  5'd0,  -16'sd5000,  16'd1},
    '{OP_DRAIN, K_ONE,  5'd0,  16'sd0,      16'd16},
    '{OP_OPEN,  K_ONE,  5'd0,  16'sd0,      16'd0},
    '{OP_OPEN,  K_ONE,  5'd0,  16'sd1,      16'd0}
  };

  logic                  bus_clk = 1'b0;
  logic                  reset;
  logic                  thr_wren;
  logic                  thr_rden;
  spike_pkg::ch_t        thr_addr;
  spike_pkg::sample_t    thr_wdata;
  spike_pkg::sample_t    thr_rdata;
  logic                  sample_valid;
  spike_pkg::ch_t        sample_ch;
  spike_pkg::sample_t    sample_data;
  logic                  running;
  logic                  spk_open;
  logic                  spk_rden;
  logic                  spk_empty;
  spike_pkg::host_word_t spk_rdata;
  logic                  overflow;

  // Reference model state
  spike_pkg::sample_t     thr_m [`SPK_NUM_CH];
  logic [`SPK_NUM_CH-1:0] armed_m;
  spike_pkg::frame_t      frame_m;
  logic                   ovf_m;
  spike_pkg::spk_rec_t    exp_q [$];

  spike_sort_top u_spike_sort_top (.*);

  always #2 bus_clk = ~bus_clk;

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      $display("FAILED %s exp=%h got=%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic write_thr(input spike_pkg::ch_t ch, input spike_pkg::sample_t v);
    @(posedge bus_clk);
    thr_wren  <= 1'b1;
    thr_addr  <= ch;
    thr_wdata <= v;
    @(posedge bus_clk);
    thr_wren <= 1'b0;
    thr_rden <= 1'b1;
    @(posedge bus_clk);
    thr_rden <= 1'b0;
    @(negedge bus_clk);
    check("thr_rdata", v, thr_rdata);
    thr_m[ch] = v;
  endtask

  task automatic send_frames(input row_t r);
    spike_pkg::sample_t s;
    for (int f = 0; f < r.n; f++) begin
      for (int c = 0; c < `SPK_NUM_CH; c++) begin
        if (r.kind == K_RAND) begin
          s = spike_pkg::sample_t'(int'($urandom % 2400) - 1200);
        end else if (r.kind == K_ALL || c == r.ch) begin
          s = r.val;
        end else begin
          s = 16'sh7fff;
        end
        @(posedge bus_clk);
        sample_valid <= 1'b1;
        sample_ch    <= spike_pkg::ch_t'(c);
        sample_data  <= s;
        // Armed channel crossing downward gives a record unless the queue is full
        if (s < thr_m[c]) begin
          if (armed_m[c] && exp_q.size() < `SPK_FIFO_DEPTH) begin
            exp_q.push_back({frame_m, 32'(c)});
          end else if (armed_m[c]) begin
            ovf_m = 1'b1;
          end
          armed_m[c] = 1'b0;
        end else begin
          armed_m[c] = 1'b1;
        end
      end
      frame_m = frame_m + 1;
    end
    @(posedge bus_clk);
    sample_valid <= 1'b0;
  endtask

  task automatic read_word(input logic [31:0] exp, input string name);
    int cnt;
    cnt = 0;
    @(negedge bus_clk);
    while (spk_empty) begin
      if (cnt == TIMEOUT) begin
        $display("Timed out waiting for spk_empty to fall on a predicted record");
        abort_run();
      end
      cnt++;
      @(negedge bus_clk);
    end
    check(name, exp, spk_rdata);
    @(posedge bus_clk);
    spk_rden <= 1'b1;
    @(posedge bus_clk);
    spk_rden <= 1'b0;
  endtask

  task automatic drain_records(input logic [15:0] n);
    spike_pkg::spk_rec_t rec;
    int                  got;
    got = 0;
    while (exp_q.size() > 0) begin
      rec = exp_q.pop_front();
      read_word(rec[63:32], "spk_rdata frame word");
      read_word(rec[31:0], "spk_rdata channel word");
      got++;
    end
    // Any extra record has left the three-stage sample path by now
    repeat (4) @(posedge bus_clk);
    @(negedge bus_clk);
    check("spk_empty", 1, spk_empty);
    check("overflow", ovf_m, overflow);
    if (n != 16'hffff) begin
      check("record count", n, got);
    end
  endtask

  initial begin
    reset        = 1'b1;
    thr_wren     = 1'b0;
    thr_rden     = 1'b0;
    thr_addr     = '0;
    thr_wdata    = '0;
    sample_valid = 1'b0;
    sample_ch    = '0;
    sample_data  = '0;
    running      = 1'b0;
    spk_open     = 1'b1;
    spk_rden     = 1'b0;
    armed_m      = '1;
    frame_m      = '0;
    ovf_m        = 1'b0;
    void'($urandom(32'h4402_1aae));
    repeat (8) @(posedge bus_clk);
    reset <= 1'b0;
    @(negedge bus_clk);
    check("spk_empty", 1, spk_empty);
    check("overflow", 0, overflow);
    // Default threshold on every channel before the table runs
    for (int c = 0; c < `SPK_NUM_CH; c++) begin
      write_thr(spike_pkg::ch_t'(c), -16'sd1000);
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      case (ROWS[i].op)
        OP_THR:   write_thr(ROWS[i].ch, ROWS[i].val);
        OP_FRAME: send_frames(ROWS[i]);
        OP_RUN: begin
          @(posedge bus_clk);
          running <= ROWS[i].val[0];
          // Idle state re-arms all channels and restarts frame numbering
          frame_m = '0;
          armed_m = '1;
          repeat (3) @(posedge bus_clk);
        end
        OP_OPEN: begin
          @(posedge bus_clk);
          spk_open <= ROWS[i].val[0];
          if (!ROWS[i].val[0]) begin
            exp_q.delete();
            ovf_m = 1'b0;
          end
          repeat (2) @(posedge bus_clk);
          @(negedge bus_clk);
          check("spk_empty", 1, spk_empty);
          check("overflow", ovf_m, overflow);
        end
        OP_DRAIN: drain_records(ROWS[i].n);
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* thr_ram.sv */
`timescale 1ns/1ps
`include "spike_config.svh"

module thr_ram (
  input  logic                bus_clk,
  input  logic                thr_wren,
  input  logic                thr_rden,
  input  spike_pkg::ch_t      thr_addr,
  input  spike_pkg::sample_t  thr_wdata,
  output spike_pkg::sample_t  thr_rdata,
  input  logic                sample_valid,
  input  spike_pkg::ch_t      sample_ch,
  input  spike_pkg::sample_t  sample_data,
  mua_if.src                  mua
);

  // One threshold per channel
  spike_pkg::sample_t thr_mem [`SPK_NUM_CH];

  // Host port
  always_ff @(posedge bus_clk) begin
    if (thr_wren) begin
      thr_mem[thr_addr] <= thr_wdata;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (thr_rden) begin
      thr_rdata <= thr_mem[thr_addr];
    end
  end

  // Lookup port, sample delayed to line up with its threshold
  always_ff @(posedge bus_clk) begin
    mua.valid  <= sample_valid;
    mua.ch     <= sample_ch;
    mua.sample <= sample_data;
    mua.thr    <= thr_mem[sample_ch];
  end

endmodule
